//--- pinballTop.f
common/pinballPkg.sv
common/collisionIf.sv
source/frameTimer.sv
source/gameFsm.sv
ball/collisionDetect.sv
ball/ballController.sv
source/pinballTop.sv
test/pinballTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the pinball testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module pinballTb -f pinballTop.f -o pinballSim > build.log 2>&1 &&
./obj_dir/pinballSim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

//--- test/pinballTb.sv
module pinballTb;

	timeunit 1ns;
	timeprecision 100ps;

	// about 215 frames of idle and play, plus the time spent paused
	localparam int MAX_CYCLES = 230 * pinballPkg::FRAME_CYCLES + 280;
	localparam int FP = pinballPkg::FIXED_POINT_MULTIPLIER;

	typedef struct packed {
		pinballPkg::gameState state;
		logic startD;
		logic pauseD;
		int count;
		int xPos;
		int yPos;
		int xSpeed;
		int ySpeed;
	} modelState;

	logic clk;
	logic resetN;
	logic startKey;
	logic pauseKey;
	logic flipKey;
	logic signed [10:0] topLeftX;
	logic signed [10:0] topLeftY;
	logic frameStart;

	modelState model;
	string testName = "reset";
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int seed = 38;

	pinballTop dut0 (
		.clk		(clk),
		.resetN		(resetN),
		.startKey	(startKey),
		.pauseKey	(pauseKey),
		.flipKey	(flipKey),
		.topLeftX	(topLeftX),
		.topLeftY	(topLeftY),
		.frameStart	(frameStart)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model, one call per clock edge
	//////////////////////////////////////////////////////////////////////

	function automatic modelState initialModel();
		modelState m;
		m.state = pinballPkg::IDLE;
		m.startD = 1'b0;
		m.pauseD = 1'b0;
		m.count = 0;
		m.xPos = pinballPkg::BALL_INIT_X * FP;
		m.yPos = pinballPkg::BALL_INIT_Y * FP;
		m.xSpeed = 0;
		m.ySpeed = 0;
		return m;
	endfunction

	function automatic logic frameDue(modelState m);
		return (m.state == pinballPkg::PLAY) && (m.count == pinballPkg::FRAME_CYCLES - 1);
	endfunction

	function automatic modelState modelStep(modelState m, logic start, logic pauseIn,
			logic flip);
		modelState n;
		int px;
		int py;
		logic kick;
		n = m;
		px = m.xPos / FP;
		py = m.yPos / FP;
		kick = flip && (px + pinballPkg::BALL_SIZE >= pinballPkg::FLIPPER_LEFT) &&
			(px <= pinballPkg::FLIPPER_RIGHT) && (py <= pinballPkg::FLIPPER_TOP) &&
			(py + pinballPkg::BALL_SIZE >= pinballPkg::FLIPPER_TOP) && (m.ySpeed > 0);
		if (m.state == pinballPkg::PLAY) begin
			n.count = frameDue(m) ? 0 : m.count + 1;	// holds while paused
		end
		if (m.state == pinballPkg::DRAIN) begin
			n = initialModel();
			n.count = m.count;
		end
		else if (frameDue(m)) begin
			n.xPos = m.xPos + m.xSpeed;
			n.yPos = m.yPos + m.ySpeed;
			n.ySpeed = m.ySpeed + pinballPkg::GRAVITY;
		end
		else if (m.state == pinballPkg::PLAY) begin
			if ((py <= pinballPkg::BORDER_TOP) && (m.ySpeed < 0)) n.ySpeed = -m.ySpeed;
			else if (kick) n.ySpeed = -pinballPkg::FLIPPER_KICK_Y;
			if (((px <= pinballPkg::BORDER_LEFT) && (m.xSpeed < 0)) ||
					((px + pinballPkg::BALL_SIZE >= pinballPkg::BORDER_RIGHT) &&
					(m.xSpeed > 0))) n.xSpeed = -m.xSpeed;
			else if (kick) n.xSpeed = m.xSpeed + pinballPkg::FLIPPER_KICK_X;
		end
		case (m.state)
			pinballPkg::IDLE:	if (start && !m.startD) n.state = pinballPkg::PLAY;
			pinballPkg::PLAY: begin
				if (py >= pinballPkg::DRAIN_Y) n.state = pinballPkg::DRAIN;
				else if (pauseIn && !m.pauseD) n.state = pinballPkg::PAUSED;
			end
			pinballPkg::PAUSED:	if (pauseIn && !m.pauseD) n.state = pinballPkg::PLAY;
			default:		n.state = pinballPkg::IDLE;
		endcase
		n.startD = start;
		n.pauseD = pauseIn;
		return n;
	endfunction

	always @(posedge clk) begin
		if (!resetN) model = initialModel();
		else model = modelStep(model, startKey, pauseKey, flipKey);
	end

	//////////////////////////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////////////////////////

	task automatic reportMismatch(string what, int expected, int actual);
		errors++;
		$display("ERROR %s %s: expected %0d, actual %0d", testName, what, expected, actual);
	endtask

	task automatic expectInit();
		checks += 3;
		if (int'(topLeftX) != pinballPkg::BALL_INIT_X)
			reportMismatch("x", pinballPkg::BALL_INIT_X, int'(topLeftX));
		if (int'(topLeftY) != pinballPkg::BALL_INIT_Y)
			reportMismatch("y", pinballPkg::BALL_INIT_Y, int'(topLeftY));
		if (frameStart !== 1'b0) reportMismatch("frameStart", 0, int'(frameStart));
	endtask

	initial begin : compareFrames
		forever begin
			@(negedge clk);
			if (resetN === 1'b1 && frameStart === 1'b1) begin
				@(negedge clk);	// new pixel is out one cycle later
				checks += 2;
				if (int'(topLeftX) != model.xPos / FP)
					reportMismatch("x", model.xPos / FP, int'(topLeftX));
				if (int'(topLeftY) != model.yPos / FP)
					reportMismatch("y", model.yPos / FP, int'(topLeftY));
			end
		end
	end

	initial begin : compareStrobe
		forever begin
			@(negedge clk);
			if (resetN === 1'b1) begin
				checks++;
				if (frameStart !== frameDue(model))
					reportMismatch("frameStart", int'(frameDue(model)), int'(frameStart));
			end
		end
	end

	task automatic finishRun();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end
		else begin
			$display("Errors found");
		end
		$finish;
	endtask

	initial begin : watchdog
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
		errors++;
		finishRun();
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic waitCycles(int n);
		repeat (n) @(posedge clk);
		#10;
	endtask

	initial begin : stimulus
		int hold;
		int gap;
		int lastY;
		int frozenX;
		int frozenY;
		resetN = 1'b0;
		startKey = 1'b0;
		pauseKey = 1'b0;
		flipKey = 1'b0;
		waitCycles(5);
		resetN = 1'b1;

		testName = "reset state";
		repeat (3 * pinballPkg::FRAME_CYCLES) begin
			@(negedge clk);
			expectInit();
		end

		testName = "free fall";
		waitCycles(1);
		startKey = 1'b1;
		waitCycles(2);
		startKey = 1'b0;
		while (int'(topLeftY) < pinballPkg::FLIPPER_TOP - pinballPkg::BALL_SIZE - 32)
			waitCycles(1);

		// random taps while the ball is still above the flipper surface
		testName = "flipper kick";
		while (int'(topLeftY) < pinballPkg::FLIPPER_TOP - pinballPkg::BALL_SIZE - 12) begin
			hold = 1 + int'($unsigned($random(seed)) % 32);
			gap = 1 + int'($unsigned($random(seed)) % 32);
			flipKey = 1'b1;
			waitCycles(hold);
			flipKey = 1'b0;
			waitCycles(gap);
		end

		// released flipper lets the ball sink into the flipper line
		testName = "flipper release";
		while (int'(topLeftY) < pinballPkg::FLIPPER_TOP - pinballPkg::BALL_SIZE)
			waitCycles(1);
		lastY = int'(topLeftY);
		while (int'(topLeftY) == lastY) waitCycles(1);	// one more frame with it down

		testName = "flipper kick";
		flipKey = 1'b1;
		lastY = int'(topLeftY);
		while (int'(topLeftY) >= lastY) begin	// held until the ball turns upward
			lastY = int'(topLeftY);
			waitCycles(1);
		end
		flipKey = 1'b0;

		testName = "pause";
		waitCycles(100 + int'($unsigned($random(seed)) % 400));
		pauseKey = 1'b1;
		waitCycles(3);
		pauseKey = 1'b0;
		frozenX = int'(topLeftX);
		frozenY = int'(topLeftY);
		repeat (3 * pinballPkg::FRAME_CYCLES) begin
			@(negedge clk);
			checks += 3;
			if (int'(topLeftX) != frozenX) reportMismatch("x", frozenX, int'(topLeftX));
			if (int'(topLeftY) != frozenY) reportMismatch("y", frozenY, int'(topLeftY));
			if (frameStart !== 1'b0) reportMismatch("frameStart", 0, int'(frameStart));
		end
		waitCycles(1);
		pauseKey = 1'b1;
		waitCycles(3);
		pauseKey = 1'b0;

		testName = "wall bounce";
		while (int'(topLeftY) < pinballPkg::FLIPPER_TOP) waitCycles(1);
		testName = "drain";
		while (int'(topLeftY) < pinballPkg::DRAIN_Y) waitCycles(1);
		waitCycles(3);
		repeat (2 * pinballPkg::FRAME_CYCLES) begin
			@(negedge clk);
			expectInit();
		end
		finishRun();
	end

endmodule

//--- source/pinballTop.sv
module pinballTop (
	input	logic				clk,
	input	logic				resetN,
	input	logic				startKey,
	input	logic				pauseKey,
	input	logic				flipKey,
	output	logic signed	[10:0]		topLeftX,
	output	logic signed	[10:0]		topLeftY,
	output	logic				frameStart
);

	logic pause;
	logic resetLevel;

	collisionIf col ();

	frameTimer frameTimer0 (
		.clk		(clk),
		.resetN		(resetN),
		.pause		(pause),
		.startOfFrame	(frameStart)	// also the display sync output
	);

	gameFsm gameFsm0 (
		.clk		(clk),
		.resetN		(resetN),
		.startKey	(startKey),
		.pauseKey	(pauseKey),
		.col		(col.game),
		.pause		(pause),
		.resetLevel	(resetLevel)
	);

	collisionDetect collisionDetect0 (
		.topLeftX	(topLeftX),
		.topLeftY	(topLeftY),
		.flipKey	(flipKey),
		.col		(col.detector)
	);

	ballController ballController0 (
		.clk		(clk),
		.resetN		(resetN),
		.startOfFrame	(frameStart),
		.pause		(pause),
		.resetLevel	(resetLevel),
		.col		(col.ball),
		.topLeftX	(topLeftX),
		.topLeftY	(topLeftY)
	);

endmodule

//--- ball/ballController.sv
module ballController (
	input	logic				clk,
	input	logic				resetN,
	input	logic				startOfFrame,
	input	logic				pause,
	input	logic				resetLevel,
	collisionIf.ball			col,
	output	logic signed	[10:0]		topLeftX,
	output	logic signed	[10:0]		topLeftY
);

	int xSpeed;
	int ySpeed;
	int xPos;	// fixed point
	int yPos;

	//////////////////////////////////////////////////////////////////////
	// vertical motion
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			ySpeed <= 0;
			yPos <= pinballPkg::BALL_INIT_Y * pinballPkg::FIXED_POINT_MULTIPLIER;
		end
		else if (resetLevel) begin
			ySpeed <= 0;
			yPos <= pinballPkg::BALL_INIT_Y * pinballPkg::FIXED_POINT_MULTIPLIER;
		end
		else if (!pause) begin
			if (startOfFrame) begin
				yPos <= yPos + ySpeed;
				ySpeed <= ySpeed + pinballPkg::GRAVITY;
			end
			else if (col.hitTop && (ySpeed < 0)) begin
				ySpeed <= -ySpeed;	// bounce off the ceiling
			end
			else if (col.hitFlipper && (ySpeed > 0)) begin
				ySpeed <= -pinballPkg::FLIPPER_KICK_Y;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// horizontal motion
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xSpeed <= 0;
			xPos <= pinballPkg::BALL_INIT_X * pinballPkg::FIXED_POINT_MULTIPLIER;
		end
		else if (resetLevel) begin
			xSpeed <= 0;
			xPos <= pinballPkg::BALL_INIT_X * pinballPkg::FIXED_POINT_MULTIPLIER;
		end
		else if (!pause) begin
			if (startOfFrame) begin
				xPos <= xPos + xSpeed;
			end
			else if ((col.hitLeft && (xSpeed < 0)) || (col.hitRight && (xSpeed > 0))) begin
				xSpeed <= -xSpeed;
			end
			else if (col.hitFlipper && (ySpeed > 0)) begin
				// same cycle as the vertical kick
				xSpeed <= xSpeed + pinballPkg::FLIPPER_KICK_X;
			end
		end
	end

	assign topLeftX = 11'(xPos / pinballPkg::FIXED_POINT_MULTIPLIER);
	assign topLeftY = 11'(yPos / pinballPkg::FIXED_POINT_MULTIPLIER);

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	frozenWhilePaused: assert property (
		@(posedge clk) disable iff (!resetN)
		(pause && !resetLevel) |=> ($stable(xPos) && $stable(yPos))
	) else $error("ball moved while paused");

endmodule

//--- ball/collisionDetect.sv
module collisionDetect (
	input	logic signed	[10:0]	topLeftX,
	input	logic signed	[10:0]	topLeftY,
	input	logic			flipKey,
	collisionIf.detector		col
);

	int ballRight;
	int ballBottom;
	logic overFlipper;
	logic onFlipperLine;

	assign ballRight = topLeftX + pinballPkg::BALL_SIZE;
	assign ballBottom = topLeftY + pinballPkg::BALL_SIZE;

	//////////////////////////////////////////////////////////////////////
	// walls and drain
	//////////////////////////////////////////////////////////////////////

	assign col.hitTop = (topLeftY <= pinballPkg::BORDER_TOP);
	assign col.hitLeft = (topLeftX <= pinballPkg::BORDER_LEFT);
	assign col.hitRight = (ballRight >= pinballPkg::BORDER_RIGHT);

	assign col.ballLost = (topLeftY >= pinballPkg::DRAIN_Y);

	//////////////////////////////////////////////////////////////////////
	// flipper
	//////////////////////////////////////////////////////////////////////

	// horizontal overlap with the flipper span
	assign overFlipper = (ballRight >= pinballPkg::FLIPPER_LEFT) &&
			(topLeftX <= pinballPkg::FLIPPER_RIGHT);

	// ball straddles the flipper surface
	assign onFlipperLine = (ballBottom >= pinballPkg::FLIPPER_TOP) &&
			(topLeftY <= pinballPkg::FLIPPER_TOP);

	// released flipper drops below the playfield
	assign col.hitFlipper = flipKey && overFlipper && onFlipperLine;

endmodule

//--- source/gameFsm.sv
module gameFsm (
	input	logic			clk,
	input	logic			resetN,
	input	logic			startKey,
	input	logic			pauseKey,
	collisionIf.game		col,
	output	logic			pause,
	output	logic			resetLevel
);

	pinballPkg::gameState state;
	pinballPkg::gameState nextState;

	logic startKeyD;
	logic pauseKeyD;
	logic startEdge;
	logic pauseEdge;

	assign startEdge = startKey && !startKeyD;
	assign pauseEdge = pauseKey && !pauseKeyD;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= pinballPkg::IDLE;
			startKeyD <= 1'b0;
			pauseKeyD <= 1'b0;
		end
		else begin
			state <= nextState;
			startKeyD <= startKey;
			pauseKeyD <= pauseKey;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			pinballPkg::IDLE:	if (startEdge) nextState = pinballPkg::PLAY;
			pinballPkg::PLAY: begin
				if (col.ballLost) nextState = pinballPkg::DRAIN;	// lost ball wins over pause
				else if (pauseEdge) nextState = pinballPkg::PAUSED;
			end
			pinballPkg::PAUSED:	if (pauseEdge) nextState = pinballPkg::PLAY;
			pinballPkg::DRAIN:	nextState = pinballPkg::IDLE;
			default:		nextState = pinballPkg::IDLE;
		endcase
	end

	assign pause = (state != pinballPkg::PLAY);
	assign resetLevel = (state == pinballPkg::DRAIN);	// DRAIN lasts one cycle

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	levelResetPulse: assert property (
		@(posedge clk) disable iff (!resetN)
		resetLevel |-> ($past(state) == pinballPkg::PLAY) ##1 !resetLevel
	) else $error("resetLevel not a single pulse after PLAY");

endmodule

//--- source/frameTimer.sv
module frameTimer (
	input	logic	clk,
	input	logic	resetN,
	input	logic	pause,
	output	logic	startOfFrame
);

	logic [$clog2(pinballPkg::FRAME_CYCLES)-1:0] cycleCount;
	logic lastCycle;

	assign lastCycle = (int'(cycleCount) == pinballPkg::FRAME_CYCLES - 1);

	// strobe only while running so a frozen count does not repeat it
	assign startOfFrame = lastCycle && !pause;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cycleCount <= '0;
		end
		else if (!pause) begin
			if (lastCycle) begin
				cycleCount <= '0;	// wrap at the frame length
			end
			else begin
				cycleCount <= cycleCount + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	frameStrobeSingle: assert property (
		@(posedge clk) disable iff (!resetN)
		startOfFrame |=> !startOfFrame
	) else $error("startOfFrame high for two cycles");

endmodule

//--- common/collisionIf.sv
interface collisionIf;

	logic hitTop;		// ball touches the top wall
	logic hitLeft;
	logic hitRight;
	logic hitFlipper;	// only while the flipper is raised
	logic ballLost;		// ball below the drain line

	modport detector (
		output hitTop,
		output hitLeft,
		output hitRight,
		output hitFlipper,
		output ballLost
	);

	modport ball (
		input hitTop,
		input hitLeft,
		input hitRight,
		input hitFlipper
	);

	modport game (input ballLost);

endinterface

//--- common/pinballPkg.sv
package pinballPkg;

	//////////////////////////////////////////////////////////////////////
	// screen geometry in pixels
	//////////////////////////////////////////////////////////////////////

	localparam int BALL_SIZE = 16;		// square ball edge
	localparam int BALL_INIT_X = 312;	// top-left corner after a level reset
	localparam int BALL_INIT_Y = 60;

	localparam int BORDER_LEFT = 20;
	localparam int BORDER_RIGHT = 620;
	localparam int BORDER_TOP = 20;

	localparam int DRAIN_Y = 460;		// ball top below this is lost

	localparam int FLIPPER_LEFT = 240;
	localparam int FLIPPER_RIGHT = 400;
	localparam int FLIPPER_TOP = 420;	// raised flipper surface

	//////////////////////////////////////////////////////////////////////
	// physics in fixed point
	//////////////////////////////////////////////////////////////////////

	localparam int FIXED_POINT_MULTIPLIER = 64;	// one pixel
	localparam int GRAVITY = 4;			// added to vertical speed each frame
	localparam int FLIPPER_KICK_X = 96;		// 1.5 px per frame sideways
	localparam int FLIPPER_KICK_Y = 640;		// 10 px per frame upward

	// short frames keep the simulation fast
	localparam int FRAME_CYCLES = 64;

	//////////////////////////////////////////////////////////////////////
	// game states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,		// waiting for start
		PLAY,
		PAUSED,
		DRAIN		// one cycle of level reset
	} gameState;

endpackage
